// ==== design/mem_pkg.sv ====
package mem_pkg;

	localparam int addr_w    = 32; // byte address
	localparam int data_w    = 64; // one bus beat carries a whole line
	localparam int mem_tag_w = 4;  // zero means no response

	// command on both the processor and the memory port
	typedef enum logic [1:0] {
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} bus_cmd_e;

	typedef enum logic [1:0] {
		size_byte   = 2'h0,
		size_half   = 2'h1,
		size_word   = 2'h2,
		size_double = 2'h3
	} mem_size_e;

	typedef struct packed {
		bus_cmd_e          command;
		mem_size_e         size;
		logic              unsigned_load; // zero extend instead of sign extend
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;         // store value, right aligned
	} proc_req_t;

	typedef struct packed {
		logic              done;  // request finished this cycle
		logic [data_w-1:0] rdata; // extended load value
	} proc_rsp_t;

	typedef struct packed {
		bus_cmd_e          command;
		logic [addr_w-1:0] addr; // always line aligned
		logic [data_w-1:0] data; // victim line on a store
	} mem_req_t;

	// response is the acceptance tag, tag marks returning load data
	typedef struct packed {
		logic [mem_tag_w-1:0] response;
		logic [data_w-1:0]    data;
		logic [mem_tag_w-1:0] tag;
	} mem_rsp_t;

endpackage

// ==== design/dcache_pkg.sv ====
package dcache_pkg;

	// direct mapped, one 8 byte line per index
	localparam int num_lines   = 32;
	localparam int offset_bits = 3;
	localparam int index_bits  = 5;
	localparam int tag_bits    = mem_pkg::addr_w - index_bits - offset_bits;

	typedef struct packed {
		logic                      valid;
		logic                      dirty; // line differs from memory
		logic [tag_bits-1:0]       tag;
		logic [mem_pkg::data_w-1:0] data;
	} cache_line_t;

	// miss sequencing
	typedef enum logic [2:0] {
		lookup     = 3'h0, // idle, or serving hits
		writeback  = 3'h1, // dirty victim going out
		fetch_req  = 3'h2, // line load waiting for acceptance
		fetch_wait = 3'h3, // waiting for the tagged data
		fill       = 3'h4  // install the fetched line
	} dcache_state_e;

endpackage

// ==== design/dcache_ctrl.sv ====
module dcache_ctrl (
	input  logic               clock,
	input  logic               reset,
	input  mem_pkg::proc_req_t proc_req,
	input  logic               hit,
	input  logic               victim_dirty,
	input  logic               accepted,
	input  logic               data_ready,
	output mem_pkg::bus_cmd_e  issue_cmd,
	output logic               fill_we,
	output logic               store_we,
	output logic               clear_dirty,
	output logic               done
);

	dcache_pkg::dcache_state_e state, state_next;

	logic active;   // processor has a request up
	logic is_store;

	assign active   = (proc_req.command != mem_pkg::bus_none);
	assign is_store = (proc_req.command == mem_pkg::bus_store);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= dcache_pkg::lookup;
		end else begin
			state <= state_next;
		end
	end

	// outputs are pure functions of state and the handshakes
	always_comb begin
		state_next  = state;
		issue_cmd   = mem_pkg::bus_none; // quiet bus unless a miss is in flight
		fill_we     = 1'b0;
		store_we    = 1'b0;
		clear_dirty = 1'b0;
		done        = 1'b0;

		case (state)
			dcache_pkg::lookup: begin
				if (active) begin
					if (hit) begin
						done     = 1'b1;     // loads and stores both finish on a hit
						store_we = is_store; // merged line written at this edge
					end else if (victim_dirty) begin
						state_next = dcache_pkg::writeback; // old line must go out first
					end else begin
						state_next = dcache_pkg::fetch_req; // invalid or clean victim
					end
				end
			end

			dcache_pkg::writeback: begin
				issue_cmd = mem_pkg::bus_store;
				if (accepted) begin
					clear_dirty = 1'b1; // memory now holds the victim
					state_next  = dcache_pkg::fetch_req;
				end
			end

			dcache_pkg::fetch_req: begin
				issue_cmd = mem_pkg::bus_load; // held until a response tag shows up
				if (accepted) begin
					state_next = dcache_pkg::fetch_wait;
				end
			end

			dcache_pkg::fetch_wait: begin
				// mem port captures the data at the matching edge
				if (data_ready) begin
					state_next = dcache_pkg::fill;
				end
			end

			dcache_pkg::fill: begin
				fill_we    = 1'b1; // clean, valid, new tag
				state_next = dcache_pkg::lookup;
			end

			default: begin
				state_next = dcache_pkg::lookup;
			end
		endcase
	end

endmodule

// ==== design/dcache_lines.sv ====
module dcache_lines (
	input  logic                        clock,
	input  logic                        reset,
	input  logic [mem_pkg::addr_w-1:0]  addr,
	input  logic                        fill_we,
	input  logic                        store_we,
	input  logic                        clear_dirty,
	input  logic [mem_pkg::data_w-1:0]  fill_data,
	input  logic [mem_pkg::data_w-1:0]  store_data,
	output logic                        hit,
	output logic                        victim_dirty,
	output dcache_pkg::cache_line_t     line
);

	dcache_pkg::cache_line_t lines [dcache_pkg::num_lines];

	logic [dcache_pkg::index_bits-1:0] index;
	logic [dcache_pkg::tag_bits-1:0]   tag;
	logic                              tag_match;

	// tag | index | offset
	assign {tag, index} = addr[mem_pkg::addr_w-1:dcache_pkg::offset_bits];

	assign line         = lines[index]; // combinational read
	assign tag_match    = (line.tag == tag);
	assign hit          = line.valid && tag_match;
	assign victim_dirty = line.valid && !tag_match && line.dirty; // needs writeback

	always_ff @(posedge clock) begin
		if (reset) begin
			// only the flags, tag and data are don't care until filled
			for (int i = 0; i < dcache_pkg::num_lines; i++) begin
				lines[i].valid <= 1'b0;
				lines[i].dirty <= 1'b0;
			end
		end else if (fill_we) begin
			lines[index].valid <= 1'b1;
			lines[index].dirty <= 1'b0; // fresh from memory
			lines[index].tag   <= tag;
			lines[index].data  <= fill_data;
		end else if (store_we) begin
			lines[index].data  <= store_data; // already merged
			lines[index].dirty <= 1'b1;
		end else if (clear_dirty) begin
			lines[index].dirty <= 1'b0; // victim accepted by memory
		end
	end

endmodule

// ==== design/dcache_lane_merge.sv ====
module dcache_lane_merge (
	input  mem_pkg::proc_req_t         req,
	input  logic [mem_pkg::data_w-1:0] line_data,
	output logic [mem_pkg::data_w-1:0] merged,
	output logic [mem_pkg::data_w-1:0] load_data
);

	logic [dcache_pkg::offset_bits-1:0] offset; // byte within the line
	logic [7:0]                         size_mask; // lanes at offset zero
	logic [7:0]                         lane_en;
	logic [mem_pkg::data_w-1:0]         wdata_shift;
	logic [mem_pkg::data_w-1:0]         line_shift;
	logic [7:0][7:0]                    line_bytes;
	logic [7:0][7:0]                    wdata_bytes;
	logic [7:0][7:0]                    merged_bytes;

	assign offset = req.addr[dcache_pkg::offset_bits-1:0];

	// accesses are naturally aligned
	always_comb begin
		case (req.size)
			mem_pkg::size_byte:   size_mask = 8'h01;
			mem_pkg::size_half:   size_mask = 8'h03;
			mem_pkg::size_word:   size_mask = 8'h0f;
			default:              size_mask = 8'hff; // double
		endcase
	end

	assign lane_en     = size_mask << offset;
	assign wdata_shift = req.wdata << {offset, 3'b000}; // move low bytes to their lanes
	assign line_bytes  = line_data;
	assign wdata_bytes = wdata_shift;

	// store merge, untouched lanes keep line contents
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			merged_bytes[i] = lane_en[i] ? wdata_bytes[i] : line_bytes[i];
		end
	end

	assign merged = merged_bytes;

	// load path, addressed bytes down to bit 0 first
	assign line_shift = line_data >> {offset, 3'b000};

	always_comb begin
		case (req.size)
			mem_pkg::size_byte: begin
				load_data = req.unsigned_load ? {56'b0, line_shift[7:0]}
				                              : {{56{line_shift[7]}}, line_shift[7:0]};
			end
			mem_pkg::size_half: begin
				load_data = req.unsigned_load ? {48'b0, line_shift[15:0]}
				                              : {{48{line_shift[15]}}, line_shift[15:0]};
			end
			mem_pkg::size_word: begin
				load_data = req.unsigned_load ? {32'b0, line_shift[31:0]}
				                              : {{32{line_shift[31]}}, line_shift[31:0]};
			end
			default: begin
				load_data = line_data; // full line, nothing to extend
			end
		endcase
	end

endmodule

// ==== design/dcache_mem_port.sv ====
module dcache_mem_port (
	input  logic                       clock,
	input  logic                       reset,
	input  mem_pkg::bus_cmd_e          issue_cmd,
	input  logic [mem_pkg::addr_w-1:0] req_addr,
	input  dcache_pkg::cache_line_t    victim,
	input  mem_pkg::mem_rsp_t          mem_rsp,
	output mem_pkg::mem_req_t          mem_req,
	output logic                       accepted,
	output logic                       data_ready,
	output logic [mem_pkg::data_w-1:0] fill_data
);

	logic [mem_pkg::mem_tag_w-1:0]     wait_tag; // tag of the outstanding load, zero if none
	logic [dcache_pkg::index_bits-1:0] req_index;

	assign req_index = req_addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];

	// held stable by the controller until acceptance
	always_comb begin
		mem_req.command = issue_cmd;
		mem_req.addr    = {req_addr[mem_pkg::addr_w-1:dcache_pkg::offset_bits],
		                   {dcache_pkg::offset_bits{1'b0}}}; // line of the request
		mem_req.data    = '0;
		if (issue_cmd == mem_pkg::bus_store) begin
			// victim sits at the same index, only its tag differs
			mem_req.addr = {victim.tag, req_index, {dcache_pkg::offset_bits{1'b0}}};
			mem_req.data = victim.data;
		end
	end

	assign accepted   = (issue_cmd != mem_pkg::bus_none) && (mem_rsp.response != '0);
	assign data_ready = (wait_tag != '0) && (mem_rsp.tag == wait_tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			wait_tag <= '0;
		end else if (accepted && issue_cmd == mem_pkg::bus_load) begin
			wait_tag <= mem_rsp.response; // store acceptances need no tracking
		end else if (data_ready) begin
			wait_tag <= '0;
		end
	end

	// data is only on the bus for one cycle
	always_ff @(posedge clock) begin
		if (data_ready) begin
			fill_data <= mem_rsp.data;
		end
	end

endmodule

// ==== design/dcache_top.sv ====
module dcache_top (
	input  logic               clock,
	input  logic               reset,
	input  mem_pkg::proc_req_t proc_req,
	output mem_pkg::proc_rsp_t proc_rsp,
	output mem_pkg::mem_req_t  mem_req,
	input  mem_pkg::mem_rsp_t  mem_rsp
);

	mem_pkg::bus_cmd_e          issue_cmd;
	dcache_pkg::cache_line_t    line; // line at the request index
	logic                       hit;
	logic                       victim_dirty;
	logic                       accepted;
	logic                       data_ready;
	logic                       fill_we;
	logic                       store_we;
	logic                       clear_dirty;
	logic                       done;
	logic [mem_pkg::data_w-1:0] fill_data;
	logic [mem_pkg::data_w-1:0] merged;    // store result for a hit
	logic [mem_pkg::data_w-1:0] load_data;

	assign proc_rsp.done  = done;
	assign proc_rsp.rdata = load_data; // only meaningful while done

	dcache_ctrl ctrl (
		.clock        (clock),
		.reset        (reset),
		.proc_req     (proc_req),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.accepted     (accepted),
		.data_ready   (data_ready),
		.issue_cmd    (issue_cmd),
		.fill_we      (fill_we),
		.store_we     (store_we),
		.clear_dirty  (clear_dirty),
		.done         (done)
	);

	dcache_lines lines (
		.clock        (clock),
		.reset        (reset),
		.addr         (proc_req.addr),
		.fill_we      (fill_we),
		.store_we     (store_we),
		.clear_dirty  (clear_dirty),
		.fill_data    (fill_data),
		.store_data   (merged),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.line         (line)
	);

	dcache_lane_merge lane_merge (
		.req       (proc_req),
		.line_data (line.data),
		.merged    (merged),
		.load_data (load_data)
	);

	dcache_mem_port mem_port (
		.clock      (clock),
		.reset      (reset),
		.issue_cmd  (issue_cmd),
		.req_addr   (proc_req.addr),
		.victim     (line),
		.mem_rsp    (mem_rsp),
		.mem_req    (mem_req),
		.accepted   (accepted),
		.data_ready (data_ready),
		.fill_data  (fill_data)
	);

endmodule

// ==== bench/tb_mem_model.sv ====
module tb_mem_model (
	input  logic              clock,
	input  logic              reset,
	input  mem_pkg::mem_req_t mem_req,
	input  logic [1:0]        accept_delay, // cycles to stall the next request
	output mem_pkg::mem_rsp_t mem_rsp
);

	logic [63:0] mem [logic [31:0]]; // written lines only
	mem_pkg::mem_rsp_t rsp_q = '0;
	int          wait_cnt = 0;
	int          ret_cnt = 0;   // cycles until load data goes out
	logic        busy = 1'b0;   // a request is being stalled
	logic [3:0]  next_tag = 4'd1;
	logic [3:0]  ret_tag = 4'd0;
	logic [63:0] ret_data = '0;

	assign mem_rsp = rsp_q;

	// same content rule as the shadow in the testbench
	function automatic logic [63:0] line_init(input logic [31:0] a);
		return {a ^ 32'h6d2b_79f5, {a[15:0], a[31:16]} + 32'h9e37_79b9};
	endfunction

	function automatic logic [63:0] read_line(input logic [31:0] a);
		if (mem.exists(a))
			return mem[a];
		return line_init(a);
	endfunction

	always @(negedge clock) begin
		if (reset) begin
			rsp_q    = '0;
			wait_cnt = 0;
			ret_cnt  = 0;
			busy     = 1'b0;
			next_tag = 4'd1;
		end else begin
			rsp_q = '0; // response and tag last one cycle
			if (ret_cnt > 0) begin
				ret_cnt--;
				if (ret_cnt == 0) begin
					rsp_q.tag  = ret_tag;
					rsp_q.data = ret_data;
				end
			end
			if (mem_req.command == mem_pkg::bus_none) begin
				busy = 1'b0;
			end else if (!busy) begin
				busy     = 1'b1; // new request, pick its stall
				wait_cnt = int'(accept_delay);
			end
			if (busy) begin
				if (wait_cnt > 0) begin
					wait_cnt--;
				end else begin
					rsp_q.response = next_tag; // acceptance cycle
					if (mem_req.command == mem_pkg::bus_store) begin
						mem[mem_req.addr] = mem_req.data;
					end else begin
						ret_tag  = next_tag;
						ret_data = read_line(mem_req.addr);
						ret_cnt  = 4;
					end
					next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1; // never zero
					busy     = 1'b0;
				end
			end
		end
	end

endmodule

// ==== bench/tb_dcache.sv ====
module tb_dcache;

	localparam int n_ops         = 423; // directed plus 400 random
	localparam int timeout_limit = 24 * n_ops + 200;

	logic               clock;
	logic               reset;
	mem_pkg::proc_req_t req;
	mem_pkg::proc_rsp_t rsp;
	mem_pkg::mem_req_t  mreq;
	mem_pkg::mem_rsp_t  mrsp;
	logic [1:0]         accept_delay = 2'd0;

	logic [31:0] lfsr = 32'd83650;
	logic [7:0]  shadow [logic [31:0]]; // bytes written by stores
	int          errors = 0;
	int          other_errors = 0;
	int          issued = 0;
	int          done_count = 0;
	int          cycles = 0;
	int          seq = 0;
	int          wb_count = 0;
	int          ld_count = 0;
	int          wb_seq = 0;
	int          ld_seq = 0;
	logic [31:0] wb_addr = '0;
	logic [63:0] wb_data = '0;

	dcache_top dut (
		.clock    (clock),
		.reset    (reset),
		.proc_req (req),
		.proc_rsp (rsp),
		.mem_req  (mreq),
		.mem_rsp  (mrsp)
	);

	tb_mem_model mem (
		.clock        (clock),
		.reset        (reset),
		.mem_req      (mreq),
		.accept_delay (accept_delay),
		.mem_rsp      (mrsp)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[62:0], fb};
		end
		return r;
	endfunction

	function automatic logic [63:0] line_init(input logic [31:0] a);
		return {a ^ 32'h6d2b_79f5, {a[15:0], a[31:16]} + 32'h9e37_79b9};
	endfunction

	function automatic logic [7:0] shadow_byte(input logic [31:0] a);
		logic [63:0] w;
		if (shadow.exists(a))
			return shadow[a];
		w = line_init({a[31:3], 3'b000});
		return w[{a[2:0], 3'b000} +: 8];
	endfunction

	function automatic logic [63:0] shadow_line(input logic [31:0] a);
		logic [63:0] v;
		for (int i = 0; i < 8; i++)
			v[i*8 +: 8] = shadow_byte({a[31:3], 3'(i)});
		return v;
	endfunction

	// expected load from little endian shadow bytes then extension
	function automatic logic [63:0] ref_load(input logic [31:0] addr,
	                                         input mem_pkg::mem_size_e size, input logic uns);
		int          n;
		logic [63:0] v;
		n = 1 << int'(size);
		v = '0;
		for (int i = 0; i < n; i++)
			v[i*8 +: 8] = shadow_byte(addr + 32'(i));
		if (!uns && n < 8) begin
			for (int b = n * 8; b < 64; b++)
				v[b] = v[n*8-1]; // sign fill
		end
		return v;
	endfunction

	task automatic shadow_store(input logic [31:0] addr, input mem_pkg::mem_size_e size,
	                            input logic [63:0] wdata);
		for (int i = 0; i < (1 << int'(size)); i++)
			shadow[addr + 32'(i)] = wdata[i*8 +: 8];
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	// drive at a falling edge and hold until the checker has seen done
	task automatic mem_op(input mem_pkg::bus_cmd_e cmd, input mem_pkg::mem_size_e size,
	                      input logic uns, input logic [31:0] addr, input logic [63:0] wdata);
		req.command       = cmd;
		req.size          = size;
		req.unsigned_load = uns;
		req.addr          = addr;
		req.wdata         = wdata;
		issued++;
		do
			@(negedge clock);
		while (done_count < issued);
	endtask

	// compares each finished load against the shadow and applies finished stores
	always @(posedge clock) begin
		if (!reset && rsp.done && done_count < issued) begin
			if (req.command == mem_pkg::bus_load)
				check_value("proc_rsp.rdata", rsp.rdata,
				            ref_load(req.addr, req.size, req.unsigned_load));
			else
				shadow_store(req.addr, req.size, req.wdata);
			done_count++;
		end
	end

	// memory side traffic log
	always @(posedge clock) begin
		seq++;
		if (mreq.command != mem_pkg::bus_none && mrsp.response != 4'd0) begin
			if (mreq.command == mem_pkg::bus_store) begin
				wb_count++;
				wb_seq  = seq;
				wb_addr = mreq.addr;
				wb_data = mreq.data;
			end else begin
				ld_count++;
				ld_seq = seq;
			end
		end
	end

	always @(posedge clock) begin
		accept_delay <= 2'(rand_bits(2));
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > timeout_limit) begin
			$display("timeout, requests still pending after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		logic [31:0]        a;
		logic [31:0]        b;
		logic [63:0]        victim_exp;
		int                 wb_before;
		int                 ld_before;
		logic [1:0]         idx;
		logic [1:0]         tg;
		logic [2:0]         off;
		mem_pkg::mem_size_e sz;
		logic               uns;
		logic               st;
		logic [63:0]        wd;

		reset = 1'b1;
		req   = '0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// idle bus and no done with nothing valid
		repeat (3) begin
			check_value("mem_req.command", 64'(mreq.command), 64'(mem_pkg::bus_none));
			check_value("proc_rsp.done", 64'(rsp.done), 64'd0);
			@(negedge clock);
		end

		// miss then hits of every size with both extensions
		a = 32'h0000_1108;
		mem_op(mem_pkg::bus_load, mem_pkg::size_double, 1'b0, a, '0);
		for (int s = 0; s < 4; s++) begin
			for (int u = 0; u < 2; u++)
				mem_op(mem_pkg::bus_load, mem_pkg::mem_size_e'(2'(s)), 1'(u),
				       a + 32'((s < 3) ? 4 - (1 << s) : 0), '0); // top of the low word
		end

		// stores of every size into one line
		mem_op(mem_pkg::bus_store, mem_pkg::size_byte, 1'b0, a + 32'd3, 64'h0000_0000_0000_009c);
		mem_op(mem_pkg::bus_store, mem_pkg::size_half, 1'b0, a + 32'd6, 64'h0000_0000_0000_8001);
		mem_op(mem_pkg::bus_load, mem_pkg::size_double, 1'b0, a, '0);
		mem_op(mem_pkg::bus_load, mem_pkg::size_byte, 1'b0, a + 32'd3, '0);
		mem_op(mem_pkg::bus_load, mem_pkg::size_half, 1'b1, a + 32'd6, '0);
		mem_op(mem_pkg::bus_store, mem_pkg::size_word, 1'b0, a, 64'h1111_1111_f00d_cafe);
		mem_op(mem_pkg::bus_load, mem_pkg::size_double, 1'b0, a, '0);
		mem_op(mem_pkg::bus_store, mem_pkg::size_byte, 1'b0, a + 32'd5, 64'h0000_0000_0000_0080);
		mem_op(mem_pkg::bus_load, mem_pkg::size_word, 1'b0, a + 32'd4, '0);
		mem_op(mem_pkg::bus_store, mem_pkg::size_double, 1'b0, a, 64'h0123_4567_89ab_cdef);
		mem_op(mem_pkg::bus_load, mem_pkg::size_double, 1'b0, a, '0);

		// dirty eviction by the same index with another tag
		b          = a + 32'h0000_0100;
		victim_exp = shadow_line(a);
		wb_before  = wb_count;
		mem_op(mem_pkg::bus_load, mem_pkg::size_double, 1'b0, b, '0);
		check_value("writeback count", 64'(wb_count), 64'(wb_before + 1));
		check_value("mem_req.addr", 64'(wb_addr), 64'({a[31:3], 3'b000}));
		check_value("mem_req.data", wb_data, victim_exp);
		if (wb_seq >= ld_seq) begin
			$display("victim writeback was not issued before the line fetch");
			other_errors++;
		end

		// clean eviction back to the old line needs only a load
		wb_before = wb_count;
		ld_before = ld_count;
		mem_op(mem_pkg::bus_load, mem_pkg::size_double, 1'b0, a, '0);
		check_value("writeback count", 64'(wb_count), 64'(wb_before));
		check_value("fetch count", 64'(ld_count), 64'(ld_before + 1));
		mem_op(mem_pkg::bus_load, mem_pkg::size_byte, 1'b0, a + 32'd3, '0);

		// random traffic over four indices and four tags
		for (int k = 0; k < 400; k++) begin
			idx = 2'(rand_bits(2));
			tg  = 2'(rand_bits(2));
			sz  = mem_pkg::mem_size_e'(2'(rand_bits(2)));
			uns = 1'(rand_bits(1));
			st  = 1'(rand_bits(1));
			off = 3'(rand_bits(3));
			wd  = rand_bits(64);
			off = 3'((int'(off) >> int'(sz)) << int'(sz)); // natural alignment
			mem_op(st ? mem_pkg::bus_store : mem_pkg::bus_load, sz, uns,
			       {24'h000040 + 24'(tg), 3'b000, idx, off}, wd);
		end

		req.command = mem_pkg::bus_none;
		repeat (4) @(negedge clock);

		$display("errors: %0d mismatches, %0d other failures", errors, other_errors);
		if (errors == 0 && other_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
design/mem_pkg.sv
design/dcache_pkg.sv
design/dcache_ctrl.sv
design/dcache_lines.sv
design/dcache_lane_merge.sv
design/dcache_mem_port.sv
design/dcache_top.sv
bench/tb_mem_model.sv
bench/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, then look for the pass line in the run output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f tb.f --top-module tb_dcache \
	&& ./obj_dir/Vtb_dcache | tee /dev/stderr \
	| grep "Simulation completed successfully" > /dev/null \
	|| { echo "cache simulation did not pass"; exit 1; }
